// File: hw/spr_defs.svh
// SPR access unit constants: widths, opcodes, group numbers, register indices, SR bits
`ifndef SPR_DEFS_SVH
`define SPR_DEFS_SVH

////////////////////
// Widths
`define SPR_WIDTH          32
`define SPR_OFS_WIDTH      16
`define SPR_GROUP_WIDTH    5     // Address bits 15:11
`define SPR_SR_WIDTH       16

////////////////////
// Opcodes from the decode stage
`define SPR_ALUOP_WIDTH    4
`define SPR_ALUOP_MTSR     14    // Move to SPR
`define SPR_ALUOP_MFSR     15    // Move from SPR
`define SPR_BRANCHOP_WIDTH 3
`define SPR_BRANCHOP_RFE   6     // Return from exception

////////////////////
// Group numbers
`define SPR_GRP_SYS        0
`define SPR_GRP_DMMU       1
`define SPR_GRP_IMMU       2
`define SPR_GRP_DU         6
`define SPR_GRP_PIC        9
`define SPR_GRP_TT         10

// System group register indices, address bits 10:0
`define SPR_IDX_NPC        16
`define SPR_IDX_SR         17
`define SPR_IDX_PPC        18
`define SPR_IDX_EPCR       32
`define SPR_IDX_EEAR       48
`define SPR_IDX_ESR        64
`define SPR_RF_BLOCK       32    // Bits 10:5 of the 32-entry RF window

////////////////////
// SR bit positions
`define SPR_SR_SM          0     // Supervisor mode
`define SPR_SR_TEE         1     // Tick timer exception enable
`define SPR_SR_IEE         2     // Interrupt exception enable
`define SPR_SR_DME         5     // Data MMU enable
`define SPR_SR_IME         6     // Insn MMU enable
`define SPR_SR_CE          8     // Context id enable
`define SPR_SR_F           9     // Compare flag
`define SPR_SR_CY          10    // Carry
`define SPR_SR_OV          11    // Overflow
`define SPR_SR_FO          15    // Fixed one
`define SPR_SR_RESET       ((16'd1 << `SPR_SR_FO) | (16'd1 << `SPR_SR_SM))

`endif

// File: hw/spr_pkg.sv
// Shared types of the SPR access unit: address views, request, hits and unit read data
`include "spr_defs.svh"

package spr_pkg;

   ////////////////////
   // SPR address views

   // Plain register view, group plus 11-bit index
   typedef struct packed {
      logic [`SPR_WIDTH-`SPR_OFS_WIDTH-1:0] upper;   // Unused by decode
      logic [`SPR_GROUP_WIDTH-1:0]          group;
      logic [10:0]                          index;
   } spr_addr_reg_t;

   // Register-file window view
   typedef struct packed {
      logic [`SPR_WIDTH-`SPR_OFS_WIDTH-1:0] upper;
      logic [`SPR_GROUP_WIDTH-1:0]          group;
      logic [5:0]                           block;   // Window select
      logic [4:0]                           entry;   // GPR number
   } spr_addr_rf_t;

   // Same word, decoded both ways in group 0
   typedef union packed {
      spr_addr_reg_t r;
      spr_addr_rf_t  f;
   } spr_addr_u;

   ////////////////////
   // One access to the SPR space
   typedef struct packed {
      spr_addr_u             addr;
      logic [`SPR_WIDTH-1:0] wdata;
      logic                  rd;      // MFSR or debug read
      logic                  wr;      // MTSR or debug write
   } spr_req_t;

   // System register hits, one per source
   typedef struct packed {
      logic rf;
      logic npc;
      logic ppc;
      logic sr;
      logic epcr;
      logic eear;
      logic esr;
   } spr_sys_hit_t;

   // Read data from the other units
   typedef struct packed {
      logic [`SPR_WIDTH-1:0] rf;
      logic [`SPR_WIDTH-1:0] npc;
      logic [`SPR_WIDTH-1:0] ppc;
      logic [`SPR_WIDTH-1:0] dmmu;
      logic [`SPR_WIDTH-1:0] immu;
      logic [`SPR_WIDTH-1:0] du;
      logic [`SPR_WIDTH-1:0] pic;
      logic [`SPR_WIDTH-1:0] tt;
   } spr_unit_rdata_t;

endpackage

// File: hw/spr_access_ctrl.sv
// SPR access control, merges CPU opcode and debug qualifiers into one SPR request
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_access_ctrl (
   input  logic [`SPR_WIDTH-1:0]       addrbase_i,   // Base from GPR
   input  logic [`SPR_OFS_WIDTH-1:0]   addrofs_i,    // Immediate offset
   input  logic [`SPR_WIDTH-1:0]       spr_wdata_i,  // MTSR data
   input  logic [`SPR_ALUOP_WIDTH-1:0] alu_op_i,
   input  logic [`SPR_WIDTH-1:0]       du_addr_i,
   input  logic [`SPR_WIDTH-1:0]       du_dat_i,
   input  logic                        du_read_i,
   input  logic                        du_write_i,
   output spr_pkg::spr_req_t           req_o,
   output logic                        spr_we_o
);

   logic                        du_access;   // Debug port owns this cycle
   logic [`SPR_ALUOP_WIDTH-1:0] sprs_op;     // Effective opcode
   logic [`SPR_WIDTH-1:0]       ofs_ext;

   assign du_access = du_read_i | du_write_i;

   // Debug qualifiers beat the CPU opcode
   always_comb begin
      if (du_write_i) begin
         sprs_op = `SPR_ALUOP_MTSR;
      end else if (du_read_i) begin
         sprs_op = `SPR_ALUOP_MFSR;
      end else begin
         sprs_op = alu_op_i;
      end
   end

   assign ofs_ext = {{(`SPR_WIDTH-`SPR_OFS_WIDTH){1'b0}}, addrofs_i};

   ////////////////////
   // Request forming
   always_comb begin
      // Base and offset are ORed, not added
      req_o.addr  = du_access ? du_addr_i : (addrbase_i | ofs_ext);
      req_o.wdata = du_write_i ? du_dat_i : spr_wdata_i;   // Debug data first
      // Opcodes are distinct so at most one strobe
      req_o.wr    = (sprs_op == `SPR_ALUOP_MTSR);
      req_o.rd    = (sprs_op == `SPR_ALUOP_MFSR);
   end

   // Unit write strobe, CPU or debug
   assign spr_we_o = req_o.wr;

endmodule

// File: hw/spr_group_decode.sv
// SPR group decode, qualified one-hot chip selects and system register hits
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_group_decode (
   input  spr_pkg::spr_req_t     req_i,
   output logic [31:0]           spr_cs_o,    // One bit per group
   output spr_pkg::spr_sys_hit_t wr_hit_o,
   output spr_pkg::spr_sys_hit_t rd_hit_o,
   output logic                  pc_we_o,     // NPC or PPC
   output logic                  epcr_we_o,
   output logic                  eear_we_o,
   output logic                  esr_we_o
);

   logic [31:0]           unq_cs;   // Group decode before qualify
   logic                  sys_cs;
   spr_pkg::spr_sys_hit_t sel;

   ////////////////////
   // Chip selects
   assign unq_cs   = 32'd1 << req_i.addr.r.group;
   assign spr_cs_o = unq_cs & {32{req_i.rd | req_i.wr}};
   assign sys_cs   = spr_cs_o[`SPR_GRP_SYS];

   // Group 0 register match, both address views
   always_comb begin
      sel.rf   = sys_cs && (req_i.addr.f.block == 6'(`SPR_RF_BLOCK));
      sel.npc  = sys_cs && (req_i.addr.r.index == 11'(`SPR_IDX_NPC));
      sel.ppc  = sys_cs && (req_i.addr.r.index == 11'(`SPR_IDX_PPC));
      sel.sr   = sys_cs && (req_i.addr.r.index == 11'(`SPR_IDX_SR));
      sel.epcr = sys_cs && (req_i.addr.r.index == 11'(`SPR_IDX_EPCR));
      sel.eear = sys_cs && (req_i.addr.r.index == 11'(`SPR_IDX_EEAR));
      sel.esr  = sys_cs && (req_i.addr.r.index == 11'(`SPR_IDX_ESR));
   end

   ////////////////////
   // Split by direction
   assign wr_hit_o = sel & {$bits(sel){req_i.wr}};
   assign rd_hit_o = sel & {$bits(sel){req_i.rd}};

   // System register write enables
   assign pc_we_o   = wr_hit_o.npc | wr_hit_o.ppc;
   assign epcr_we_o = wr_hit_o.epcr;
   assign eear_we_o = wr_hit_o.eear;
   assign esr_we_o  = wr_hit_o.esr;

endmodule

// File: hw/spr_sr_reg.sv
// Supervision register, next-value select, exception entry and RFE restore
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_sr_reg (
   input  logic                           clk,
   input  logic                           rst,
   input  spr_pkg::spr_req_t              req_i,
   input  logic                           sr_wr_i,       // SR write hit
   input  logic [`SPR_BRANCHOP_WIDTH-1:0] branch_op_i,
   input  logic [`SPR_SR_WIDTH-1:0]       esr_i,
   input  logic                           flagforw_i,    // From ALU
   input  logic                           flag_we_i,
   input  logic                           cyforw_i,      // From ALU
   input  logic                           cy_we_i,
   input  logic                           except_started_i,
   output logic [`SPR_SR_WIDTH-1:0]       sr_o,
   output logic [`SPR_SR_WIDTH-1:0]       to_sr_o,       // Next SR value
   output logic                           sr_we_o,
   output logic                           flag_o,
   output logic                           carry_o
);

   logic rfe;

   assign rfe = (branch_op_i == `SPR_BRANCHOP_RFE);

   ////////////////////
   // Next value
   always_comb begin
      to_sr_o = sr_o;   // Hold
      if (rfe) begin
         to_sr_o = esr_i;   // Whole word restored
      end else begin
         if (sr_wr_i) begin
            to_sr_o             = req_i.wdata[`SPR_SR_WIDTH-1:0];
            to_sr_o[`SPR_SR_FO] = 1'b1;   // Always reads one
         end
         // ALU flag updates override the SPR write bit by bit
         if (flag_we_i) to_sr_o[`SPR_SR_F] = flagforw_i;
         if (cy_we_i) to_sr_o[`SPR_SR_CY] = cyforw_i;
      end
   end

   assign sr_we_o = sr_wr_i | rfe | flag_we_i | cy_we_i;

   ////////////////////
   // Register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sr_o <= `SPR_SR_RESET;   // Supervisor, EPH clear
      end else if (except_started_i) begin
         // Enter supervisor with exceptions and MMUs off
         sr_o[`SPR_SR_SM]  <= 1'b1;
         sr_o[`SPR_SR_TEE] <= 1'b0;
         sr_o[`SPR_SR_IEE] <= 1'b0;
         sr_o[`SPR_SR_DME] <= 1'b0;
         sr_o[`SPR_SR_IME] <= 1'b0;
      end else if (sr_we_o) begin
         sr_o <= to_sr_o;
      end
   end

   // Aliases for the ALU and branch logic
   assign flag_o  = sr_o[`SPR_SR_F];
   assign carry_o = sr_o[`SPR_SR_CY];

endmodule

// File: hw/spr_read_mux.sv
// SPR read path, system data assembly and group mux toward writeback and debug
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_read_mux (
   input  spr_pkg::spr_req_t        req_i,
   input  spr_pkg::spr_sys_hit_t    rd_hit_i,
   input  logic [`SPR_SR_WIDTH-1:0] sr_i,
   input  logic [`SPR_WIDTH-1:0]    epcr_i,
   input  logic [`SPR_WIDTH-1:0]    eear_i,
   input  logic [`SPR_SR_WIDTH-1:0] esr_i,
   input  spr_pkg::spr_unit_rdata_t unit_rdata_i,
   input  logic [`SPR_WIDTH-1:0]    du_dat_i,
   input  logic                     du_write_i,
   input  logic                     du_read_i,
   output logic [`SPR_WIDTH-1:0]    to_wbmux_o,     // For MFSR
   output logic [`SPR_WIDTH-1:0]    du_dat_cpu_o    // Toward debug unit
);

   logic [`SPR_WIDTH-1:0] sys_data;
   logic [`SPR_WIDTH-1:0] sr_ext;
   logic [`SPR_WIDTH-1:0] esr_ext;

   assign sr_ext  = {{(`SPR_WIDTH-`SPR_SR_WIDTH){1'b0}}, sr_i};
   assign esr_ext = {{(`SPR_WIDTH-`SPR_SR_WIDTH){1'b0}}, esr_i};

   ////////////////////
   // Group 0, hits are one-hot so OR is a mux
   assign sys_data = (unit_rdata_i.rf  & {`SPR_WIDTH{rd_hit_i.rf}})   |
                     (unit_rdata_i.npc & {`SPR_WIDTH{rd_hit_i.npc}})  |
                     (unit_rdata_i.ppc & {`SPR_WIDTH{rd_hit_i.ppc}})  |
                     (sr_ext           & {`SPR_WIDTH{rd_hit_i.sr}})   |
                     (epcr_i           & {`SPR_WIDTH{rd_hit_i.epcr}}) |
                     (eear_i           & {`SPR_WIDTH{rd_hit_i.eear}}) |
                     (esr_ext          & {`SPR_WIDTH{rd_hit_i.esr}});

   // Group mux, zero when idle or unmapped
   always_comb begin
      to_wbmux_o = '0;
      if (req_i.rd) begin
         case (req_i.addr.r.group)
            `SPR_GRP_SYS:  to_wbmux_o = sys_data;
            `SPR_GRP_DMMU: to_wbmux_o = unit_rdata_i.dmmu;
            `SPR_GRP_IMMU: to_wbmux_o = unit_rdata_i.immu;
            `SPR_GRP_DU:   to_wbmux_o = unit_rdata_i.du;
            `SPR_GRP_PIC:  to_wbmux_o = unit_rdata_i.pic;
            `SPR_GRP_TT:   to_wbmux_o = unit_rdata_i.tt;
            default:       to_wbmux_o = '0;
         endcase
      end
   end

   // Debug write, debug read, else MTSR data into DU registers
   assign du_dat_cpu_o = du_write_i ? du_dat_i :
                         du_read_i  ? to_wbmux_o : req_i.wdata;

endmodule

// File: hw/spr_if_top.sv
// SPR interface top, access control with decode, SR and read mux datapaths
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_if_top (
   input  logic                           clk,
   input  logic                           rst,
   // CPU side
   input  logic                           flagforw_i,
   input  logic                           flag_we_i,
   output logic                           flag_o,
   input  logic                           cyforw_i,
   input  logic                           cy_we_i,
   output logic                           carry_o,
   input  logic [`SPR_WIDTH-1:0]          addrbase_i,
   input  logic [`SPR_OFS_WIDTH-1:0]      addrofs_i,
   input  logic [`SPR_WIDTH-1:0]          spr_wdata_i,
   input  logic [`SPR_ALUOP_WIDTH-1:0]    alu_op_i,
   input  logic [`SPR_BRANCHOP_WIDTH-1:0] branch_op_i,
   input  logic [`SPR_WIDTH-1:0]          epcr_i,
   input  logic [`SPR_WIDTH-1:0]          eear_i,
   input  logic [`SPR_SR_WIDTH-1:0]       esr_i,
   input  logic                           except_started_i,
   output logic [`SPR_WIDTH-1:0]          to_wbmux_o,
   output logic                           epcr_we_o,
   output logic                           eear_we_o,
   output logic                           esr_we_o,
   output logic                           pc_we_o,
   output logic                           sr_we_o,
   output logic [`SPR_SR_WIDTH-1:0]       to_sr_o,
   output logic [`SPR_SR_WIDTH-1:0]       sr_o,
   // Other units
   input  spr_pkg::spr_unit_rdata_t       unit_rdata_i,
   output logic [`SPR_WIDTH-1:0]          spr_addr_o,
   output logic [`SPR_WIDTH-1:0]          spr_dat_o,
   output logic [31:0]                    spr_cs_o,
   output logic                           spr_we_o,
   // Debug unit
   input  logic [`SPR_WIDTH-1:0]          du_addr_i,
   input  logic [`SPR_WIDTH-1:0]          du_dat_i,
   input  logic                           du_read_i,
   input  logic                           du_write_i,
   output logic [`SPR_WIDTH-1:0]          du_dat_cpu_o
);

   spr_pkg::spr_req_t     req;
   spr_pkg::spr_sys_hit_t wr_hit;
   spr_pkg::spr_sys_hit_t rd_hit;

   assign spr_addr_o = req.addr;
   assign spr_dat_o  = req.wdata;

   spr_access_ctrl u_ctrl (
      .addrbase_i (addrbase_i),  .addrofs_i  (addrofs_i),
      .spr_wdata_i(spr_wdata_i), .alu_op_i   (alu_op_i),
      .du_addr_i  (du_addr_i),   .du_dat_i   (du_dat_i),
      .du_read_i  (du_read_i),   .du_write_i (du_write_i),
      .req_o      (req),         .spr_we_o   (spr_we_o)
   );

   spr_group_decode u_decode (
      .req_i    (req),       .spr_cs_o (spr_cs_o),
      .wr_hit_o (wr_hit),    .rd_hit_o (rd_hit),
      .pc_we_o  (pc_we_o),   .epcr_we_o(epcr_we_o),
      .eear_we_o(eear_we_o), .esr_we_o (esr_we_o)
   );

   ////////////////////
   // SR and read path
   spr_sr_reg u_sr (
      .clk(clk), .rst(rst), .req_i(req), .sr_wr_i(wr_hit.sr),
      .branch_op_i(branch_op_i), .esr_i(esr_i),
      .flagforw_i(flagforw_i), .flag_we_i(flag_we_i),
      .cyforw_i(cyforw_i), .cy_we_i(cy_we_i),
      .except_started_i(except_started_i),
      .sr_o(sr_o), .to_sr_o(to_sr_o), .sr_we_o(sr_we_o),
      .flag_o(flag_o), .carry_o(carry_o)
   );

   spr_read_mux u_rmux (
      .req_i(req), .rd_hit_i(rd_hit), .sr_i(sr_o),
      .epcr_i(epcr_i), .eear_i(eear_i), .esr_i(esr_i),
      .unit_rdata_i(unit_rdata_i), .du_dat_i(du_dat_i),
      .du_write_i(du_write_i), .du_read_i(du_read_i),
      .to_wbmux_o(to_wbmux_o), .du_dat_cpu_o(du_dat_cpu_o)
   );

endmodule

// File: testbench/spr_if_checker.sv
// SPR interface checker, concurrent properties on chip selects, SR update and enables
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_if_checker (
   input logic                        clk,
   input logic                        rst,
   input logic [`SPR_ALUOP_WIDTH-1:0] alu_op_i,
   input logic                        du_read_i,
   input logic                        du_write_i,
   input logic                        except_started_i,
   input logic [`SPR_WIDTH-1:0]       spr_addr_o,
   input logic [31:0]                 spr_cs_o,
   input logic                        sr_we_o,
   input logic [`SPR_SR_WIDTH-1:0]    to_sr_o,
   input logic [`SPR_SR_WIDTH-1:0]    sr_o,
   input logic                        flag_o,
   input logic                        carry_o,
   input logic [3:0]                  sys_we   // PC, EPCR, EEAR, ESR
);

   int   fail_cnt = 0;   // Read by the testbench summary
   logic access;
   logic rd_only;        // MFSR or debug read, no write

   assign access  = du_read_i | du_write_i | (alu_op_i == `SPR_ALUOP_MTSR) |
                    (alu_op_i == `SPR_ALUOP_MFSR);
   assign rd_only = !du_write_i && (du_read_i || (alu_op_i == `SPR_ALUOP_MFSR));

   ////////////////////
   // Chip selects
   cs_onehot_a: assert property (@(posedge clk) disable iff (rst)
      access |-> spr_cs_o == (32'd1 << spr_addr_o[`SPR_OFS_WIDTH-1 -: `SPR_GROUP_WIDTH]))
      else begin $error("chip select is not one-hot at the addressed group"); fail_cnt++; end
   cs_idle_a: assert property (@(posedge clk) disable iff (rst) !access |-> spr_cs_o == '0)
      else begin $error("chip select active without an access"); fail_cnt++; end

   ////////////////////
   // SR update one clock later
   flag_mirror_a: assert property (@(posedge clk) disable iff (rst)
      sr_we_o && !except_started_i |=> flag_o == $past(to_sr_o[`SPR_SR_F]) &&
                                       carry_o == $past(to_sr_o[`SPR_SR_CY]))
      else begin $error("flag or carry does not follow the SR update"); fail_cnt++; end
   except_entry_a: assert property (@(posedge clk) disable iff (rst)
      except_started_i |=> sr_o[`SPR_SR_SM] && !sr_o[`SPR_SR_TEE] && !sr_o[`SPR_SR_IEE] &&
                           !sr_o[`SPR_SR_DME] && !sr_o[`SPR_SR_IME])
      else begin $error("exception entry left SR in the wrong mode"); fail_cnt++; end

   // No system write on a read
   read_no_we_a: assert property (@(posedge clk) disable iff (rst) rd_only |-> sys_we == '0)
      else begin $error("system write enable raised during a read"); fail_cnt++; end

endmodule

bind spr_if_top spr_if_checker u_checker (
   .clk(clk), .rst(rst), .alu_op_i(alu_op_i), .du_read_i(du_read_i),
   .du_write_i(du_write_i), .except_started_i(except_started_i),
   .spr_addr_o(spr_addr_o), .spr_cs_o(spr_cs_o), .sr_we_o(sr_we_o),
   .to_sr_o(to_sr_o), .sr_o(sr_o), .flag_o(flag_o), .carry_o(carry_o),
   .sys_we({pc_we_o, epcr_we_o, eear_we_o, esr_we_o})
);

// File: testbench/spr_if_tb.sv
// SPR interface testbench, directed and LFSR stimulus with immediate checks
`timescale 1ns/1ps
`include "spr_defs.svh"

module spr_if_tb;

   localparam int RESET_CYCLES = 8;
   localparam int RAND_CYCLES  = 16;
   localparam int STIM_CYCLES  = RESET_CYCLES + RAND_CYCLES + 48;   // Directed steps
   localparam int MARGIN       = 40;
   localparam logic [15:0] FO_MASK = 16'd1 << `SPR_SR_FO;

   logic clk = 1'b0;
   logic rst;
   logic flagforw_i, flag_we_i, cyforw_i, cy_we_i, except_started_i;
   logic du_read_i, du_write_i;
   logic [`SPR_WIDTH-1:0] addrbase_i, spr_wdata_i, epcr_i, eear_i, du_addr_i, du_dat_i;
   logic [`SPR_OFS_WIDTH-1:0] addrofs_i;
   logic [`SPR_ALUOP_WIDTH-1:0] alu_op_i;
   logic [`SPR_BRANCHOP_WIDTH-1:0] branch_op_i;
   logic [`SPR_SR_WIDTH-1:0] esr_i;
   spr_pkg::spr_unit_rdata_t unit_rdata_i;
   logic flag_o, carry_o, epcr_we_o, eear_we_o, esr_we_o, pc_we_o, sr_we_o, spr_we_o;
   logic [`SPR_WIDTH-1:0] to_wbmux_o, spr_addr_o, spr_dat_o, du_dat_cpu_o;
   logic [`SPR_SR_WIDTH-1:0] to_sr_o, sr_o;
   logic [31:0] spr_cs_o;

   logic [31:0] lfsr_state = 32'hcb6f08b3;
   logic [15:0] exp_sr;   // SR model
   int          errors = 0;

   spr_if_top u_spr_if_top (.*);

   always #10 clk = ~clk;

   ////////////////////
   // Helpers
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Galois taps 32,22,2,1
   endfunction

   task automatic draw(input int nbits, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value[i]   = lfsr_state[0];   // One step per bit
      end
   endtask

   function automatic logic [31:0] grp_addr(input logic [4:0] grp, input logic [10:0] idx);
      return {16'h0, grp, idx};
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // Rising edge, then every per-cycle input back to idle
   task automatic begin_cycle();
      @(posedge clk);
      alu_op_i         <= '0;
      branch_op_i      <= '0;
      addrbase_i       <= '0;
      addrofs_i        <= '0;
      spr_wdata_i      <= '0;
      du_read_i        <= 1'b0;
      du_write_i       <= 1'b0;
      flag_we_i        <= 1'b0;
      cy_we_i          <= 1'b0;
      except_started_i <= 1'b0;
   endtask

   task automatic drive_op(input logic [3:0] op, input logic [31:0] base,
                           input logic [15:0] ofs, input logic [31:0] data);
      alu_op_i    <= op;
      addrbase_i  <= base;
      addrofs_i   <= ofs;
      spr_wdata_i <= data;
   endtask

   task automatic read_check(input string name, input logic [31:0] addr,
                             input logic [31:0] exp);
      begin_cycle();
      drive_op(`SPR_ALUOP_MFSR, addr, 16'h0, 32'h0);
      @(negedge clk);   // Combinational outputs settled
      check_val(name, exp, to_wbmux_o);
      check_val("pc/epcr/eear/esr_we_o", 4'b0, {pc_we_o, epcr_we_o, eear_we_o, esr_we_o});
   endtask

   task automatic write_check(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] exp_we);
      begin_cycle();
      drive_op(`SPR_ALUOP_MTSR, addr, 16'h0, data);
      @(negedge clk);
      check_val("spr_we_o", 1'b1, spr_we_o);
      check_val("pc/epcr/eear/esr_we_o", exp_we, {pc_we_o, epcr_we_o, eear_we_o, esr_we_o});
   endtask

   // Idle cycle, SR sampled after the clock that loads it
   task automatic expect_sr(input logic [15:0] exp);
      begin_cycle();
      @(negedge clk);
      check_val("sr_o", exp, sr_o);
   endtask

   ////////////////////
   // Stimulus
   initial begin
      logic [31:0] base, ofs, data, addr, word;
      int          i;
      int          chk_errors;
      rst = 1'b1;
      {flagforw_i, flag_we_i, cyforw_i, cy_we_i, except_started_i} = '0;
      {du_read_i, du_write_i, du_addr_i, du_dat_i} = '0;
      {addrbase_i, addrofs_i, spr_wdata_i, alu_op_i, branch_op_i} = '0;
      for (i = 0; i < 8; i++) begin
         draw(32, word);
         unit_rdata_i[i*32 +: 32] = word;   // Unit words
      end
      draw(32, epcr_i);
      draw(32, eear_i);
      draw(16, word);
      esr_i = word[15:0];
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      exp_sr = `SPR_SR_RESET;
      check_val("sr_o", exp_sr, sr_o);
      check_val("spr_cs_o", 32'h0, spr_cs_o);
      check_val("pc/epcr/eear/esr_we_o", 4'b0, {pc_we_o, epcr_we_o, eear_we_o, esr_we_o});

      // Random CPU accesses, address is base OR offset
      for (i = 0; i < RAND_CYCLES; i++) begin
         draw(32, base);
         draw(16, ofs);
         draw(32, data);
         if ((base[15:0] | ofs[15:0]) == 16'(`SPR_IDX_SR)) ofs[11] = 1'b1;   // Spare SR
         addr = base | ofs;
         begin_cycle();
         drive_op(i[0] ? `SPR_ALUOP_MTSR : `SPR_ALUOP_MFSR, base, ofs[15:0], data);
         @(negedge clk);
         check_val("spr_addr_o", addr, spr_addr_o);
         check_val("spr_cs_o", 32'd1 << addr[15:11], spr_cs_o);
      end

      ////////////////////
      // Debug port priority
      draw(32, data);
      begin_cycle();
      drive_op(`SPR_ALUOP_MFSR, grp_addr(5'd8, 11'h0), 16'h0, 32'h0);   // Loses to debug
      du_write_i <= 1'b1;
      du_addr_i  <= grp_addr(`SPR_GRP_DU, 11'h010);
      du_dat_i   <= data;
      @(negedge clk);
      check_val("spr_addr_o", grp_addr(`SPR_GRP_DU, 11'h010), spr_addr_o);
      check_val("spr_dat_o", data, spr_dat_o);
      check_val("du_dat_cpu_o", data, du_dat_cpu_o);
      check_val("spr_we_o", 1'b1, spr_we_o);
      begin_cycle();
      drive_op(`SPR_ALUOP_MTSR, grp_addr(`SPR_GRP_SYS, `SPR_IDX_SR), 16'h0, 32'h0);
      du_read_i <= 1'b1;
      du_addr_i <= grp_addr(`SPR_GRP_DMMU, 11'h044);
      @(negedge clk);
      check_val("spr_addr_o", grp_addr(`SPR_GRP_DMMU, 11'h044), spr_addr_o);
      check_val("du_dat_cpu_o", unit_rdata_i.dmmu, du_dat_cpu_o);
      check_val("spr_we_o", 1'b0, spr_we_o);
      draw(32, data);
      begin_cycle();
      drive_op(`SPR_ALUOP_MTSR, grp_addr(`SPR_GRP_DU, 11'h020), 16'h0, data);
      @(negedge clk);
      check_val("spr_dat_o", data, spr_dat_o);
      check_val("du_dat_cpu_o", data, du_dat_cpu_o);   // MTSR data to DU

      ////////////////////
      // SR write, then ALU flag updates
      draw(32, data);
      begin_cycle();
      drive_op(`SPR_ALUOP_MTSR, grp_addr(`SPR_GRP_SYS, `SPR_IDX_SR), 16'h0, data);
      @(negedge clk);
      exp_sr = data[15:0] | FO_MASK;
      check_val("sr_we_o", 1'b1, sr_we_o);
      check_val("to_sr_o", exp_sr, to_sr_o);
      expect_sr(exp_sr);
      draw(32, data);
      begin_cycle();
      drive_op(`SPR_ALUOP_MTSR, grp_addr(`SPR_GRP_SYS, `SPR_IDX_SR), 16'h0, data);
      flag_we_i  <= 1'b1;   // Both beat the write data
      flagforw_i <= ~data[`SPR_SR_F];
      cy_we_i    <= 1'b1;
      cyforw_i   <= ~data[`SPR_SR_CY];
      @(negedge clk);
      exp_sr = data[15:0] | FO_MASK;
      exp_sr[`SPR_SR_F]  = ~data[`SPR_SR_F];
      exp_sr[`SPR_SR_CY] = ~data[`SPR_SR_CY];
      expect_sr(exp_sr);
      begin_cycle();
      flag_we_i  <= 1'b1;
      flagforw_i <= ~exp_sr[`SPR_SR_F];
      @(negedge clk);
      check_val("sr_we_o", 1'b1, sr_we_o);
      exp_sr[`SPR_SR_F] = ~exp_sr[`SPR_SR_F];
      expect_sr(exp_sr);
      begin_cycle();
      cy_we_i  <= 1'b1;
      cyforw_i <= ~exp_sr[`SPR_SR_CY];
      @(negedge clk);
      exp_sr[`SPR_SR_CY] = ~exp_sr[`SPR_SR_CY];
      expect_sr(exp_sr);

      ////////////////////
      // Exception entry and RFE
      write_check(grp_addr(`SPR_GRP_SYS, `SPR_IDX_SR), 32'h0000_0166, 4'b0);
      exp_sr = 16'h0166 | FO_MASK;   // User mode, enables on
      expect_sr(exp_sr);
      begin_cycle();
      drive_op(`SPR_ALUOP_MTSR, grp_addr(`SPR_GRP_SYS, `SPR_IDX_SR), 16'h0, 32'h0000_0e00);
      except_started_i <= 1'b1;
      @(negedge clk);
      exp_sr[`SPR_SR_SM] = 1'b1;
      {exp_sr[`SPR_SR_TEE], exp_sr[`SPR_SR_IEE]} = 2'b00;
      {exp_sr[`SPR_SR_DME], exp_sr[`SPR_SR_IME]} = 2'b00;
      expect_sr(exp_sr);
      draw(16, word);
      begin_cycle();
      branch_op_i <= `SPR_BRANCHOP_RFE;
      esr_i       <= word[15:0];
      @(negedge clk);
      check_val("sr_we_o", 1'b1, sr_we_o);
      check_val("to_sr_o", word[15:0], to_sr_o);
      exp_sr = word[15:0];
      expect_sr(exp_sr);

      ////////////////////
      // Read mux
      draw(11, word);
      read_check("to_wbmux_o dmmu", grp_addr(`SPR_GRP_DMMU, word[10:0]), unit_rdata_i.dmmu);
      read_check("to_wbmux_o immu", grp_addr(`SPR_GRP_IMMU, word[10:0]), unit_rdata_i.immu);
      read_check("to_wbmux_o du", grp_addr(`SPR_GRP_DU, word[10:0]), unit_rdata_i.du);
      read_check("to_wbmux_o pic", grp_addr(`SPR_GRP_PIC, word[10:0]), unit_rdata_i.pic);
      read_check("to_wbmux_o tt", grp_addr(`SPR_GRP_TT, word[10:0]), unit_rdata_i.tt);
      read_check("to_wbmux_o unmapped", grp_addr(5'd3, word[10:0]), 32'h0);
      read_check("to_wbmux_o no sys hit", grp_addr(`SPR_GRP_SYS, 11'h005), 32'h0);
      read_check("to_wbmux_o npc", grp_addr(`SPR_GRP_SYS, `SPR_IDX_NPC), unit_rdata_i.npc);
      read_check("to_wbmux_o ppc", grp_addr(`SPR_GRP_SYS, `SPR_IDX_PPC), unit_rdata_i.ppc);
      read_check("to_wbmux_o rf", grp_addr(`SPR_GRP_SYS, {6'd32, word[4:0]}), unit_rdata_i.rf);
      read_check("to_wbmux_o epcr", grp_addr(`SPR_GRP_SYS, `SPR_IDX_EPCR), epcr_i);
      read_check("to_wbmux_o eear", grp_addr(`SPR_GRP_SYS, `SPR_IDX_EEAR), eear_i);
      read_check("to_wbmux_o sr", grp_addr(`SPR_GRP_SYS, `SPR_IDX_SR), {16'h0, exp_sr});
      read_check("to_wbmux_o esr", grp_addr(`SPR_GRP_SYS, `SPR_IDX_ESR), {16'h0, esr_i});

      // System write enables
      write_check(grp_addr(`SPR_GRP_SYS, `SPR_IDX_NPC), 32'h0000_1000, 4'b1000);
      write_check(grp_addr(`SPR_GRP_SYS, `SPR_IDX_PPC), 32'h0000_2000, 4'b1000);
      write_check(grp_addr(`SPR_GRP_SYS, `SPR_IDX_EPCR), 32'h0000_3000, 4'b0100);
      write_check(grp_addr(`SPR_GRP_SYS, `SPR_IDX_EEAR), 32'h0000_4000, 4'b0010);
      write_check(grp_addr(`SPR_GRP_SYS, `SPR_IDX_ESR), 32'h0000_5000, 4'b0001);

      begin_cycle();
      @(negedge clk);
      chk_errors = u_spr_if_top.u_checker.fail_cnt;
      $display("Errors: testbench %0d, checker %0d", errors, chk_errors);
      if (errors == 0 && chk_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Watchdog sized from the stimulus length
   initial begin
      #((STIM_CYCLES + MARGIN) * 20);
      $display("Watchdog timeout, stimulus did not finish in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: project.f
+incdir+hw
hw/spr_pkg.sv
hw/spr_access_ctrl.sv
hw/spr_group_decode.sv
hw/spr_sr_reg.sv
hw/spr_read_mux.sv
hw/spr_if_top.sv
testbench/spr_if_checker.sv
testbench/spr_if_tb.sv
